/* verilog/vic_cfg.svh */
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// Last raster_x value of a line for each chip
`define RASTER_X_MAX_R56A    10'd511
`define RASTER_X_MAX_R8      10'd519
`define RASTER_X_MAX_6569    10'd503

// Last raster line of a frame for each chip
`define RASTER_Y_MAX_R56A    9'd261
`define RASTER_Y_MAX_R8      9'd262
`define RASTER_Y_MAX_6569    9'd311

// xpos at the start of a line and after reset
`define XPOS_START_6567      10'h19c
`define XPOS_START_6569      10'h194

// xpos loaded on the first dot of cycle 0
`define XPOS_FIRST_6567      10'h19d
`define XPOS_FIRST_6569      10'h195

// xpos held by the 6567R8 around cycles 60 and 61
`define XPOS_HOLD_R8         10'h184

// sprite_raster_x start so that sprite 0 ba falls at zero
`define SPRITE_X_START_R56A  10'd72
`define SPRITE_X_START_R8    10'd80
`define SPRITE_X_START_6569  10'd72

// Bad line window and ba cycle numbers
`define BADLINE_FIRST        9'h030
`define BADLINE_LAST         9'h0f7
`define BA_FALL_CYCLE        7'd12
`define BA_DMA_CYCLE         7'd15
`define BA_RISE_CYCLE        7'd55

`endif

/* verilog/vic_pkg.sv */
`default_nettype none

// Types shared by the video timing blocks
package vic_pkg;

    // Chip model select
    typedef enum logic [1:0] {
        CHIP6567R56A = 2'd0,
        CHIP6567R8   = 2'd1,
        CHIP6569     = 2'd2,
        CHIPUNUSED   = 2'd3
    } chip_t;

    // Bus arbitration for character fetches
    typedef enum logic [1:0] {
        BUS_IDLE    = 2'd0,
        BUS_BA_WARN = 2'd1,
        BUS_BA_DMA  = 2'd2,
        BUS_RELEASE = 2'd3
    } bus_state_t;

endpackage : vic_pkg

`default_nettype wire

/* verilog/dot_clock_gen.sv */
`default_nettype none

// Dot strobes and phi level from the 4x dot clock
module dot_clock_gen (
    input  wire  clk_dot4x,
    input  wire  rst,
    output logic dot_rising_0,
    output logic dot_rising_2,
    output logic clk_phi,
    output logic phi_phase_start_0
);

    // 32 clocks per phi cycle, 4 clocks per dot
    logic [4:0] phase_cnt;
    logic [4:0] phase_next;

    assign phase_next = phase_cnt + 5'd1;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_cnt <= 5'd0;
        end else begin
            phase_cnt <= phase_next;
        end
    end

    // Strobes are decoded from the next count so that each one is
    // high in the same clock as the count it belongs to
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // Count 0 is the first clock out of reset
            dot_rising_0      <= 1'b1;
            dot_rising_2      <= 1'b0;
            clk_phi           <= 1'b0;
            phi_phase_start_0 <= 1'b1;
        end else begin
            dot_rising_0      <= (phase_next[1:0] == 2'd0);
            dot_rising_2      <= (phase_next[1:0] == 2'd2);
            // Low for counts 0 to 15 and high for 16 to 31
            clk_phi           <= phase_next[4];
            phi_phase_start_0 <= (phase_next == 5'd0);
        end
    end

endmodule : dot_clock_gen

`default_nettype wire

/* verilog/line_timing.sv */
`default_nettype none

`include "vic_cfg.svh"

// Bus cycle counter and per chip line limits
module line_timing
    import vic_pkg::*;
(
    input  wire        clk_dot4x,
    input  wire        rst,
    input  wire chip_t chip,
    input  wire        phi_phase_start_0,
    output logic [6:0] cycle_num,
    output logic [9:0] raster_x_max,
    output logic [8:0] raster_y_max
);

    logic [9:0] x_max_sel;
    logic [8:0] y_max_sel;
    logic [6:0] last_cycle;
    logic       first_cycle;

    // Eight dots per bus cycle
    function automatic logic [6:0] last_cycle_of(input logic [9:0] x_max);
        logic [9:0] cycles;
        cycles = (x_max + 10'd1) >> 3;
        return cycles[6:0] - 7'd1;
    endfunction

    always_comb begin
        case (chip)
            CHIP6567R56A: begin
                x_max_sel = `RASTER_X_MAX_R56A;
                y_max_sel = `RASTER_Y_MAX_R56A;
            end
            CHIP6567R8: begin
                x_max_sel = `RASTER_X_MAX_R8;
                y_max_sel = `RASTER_Y_MAX_R8;
            end
            default: begin
                x_max_sel = `RASTER_X_MAX_6569;
                y_max_sel = `RASTER_Y_MAX_6569;
            end
        endcase
    end

    // Limits are captured while in reset and then held
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_max <= x_max_sel;
            raster_y_max <= y_max_sel;
            last_cycle   <= last_cycle_of(x_max_sel);
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle_num   <= 7'd0;
            first_cycle <= 1'b1;
        end else if (phi_phase_start_0) begin
            // First phase start after reset opens cycle 0
            if (first_cycle) begin
                first_cycle <= 1'b0;
            end else if (cycle_num == last_cycle) begin
                cycle_num <= 7'd0;
            end else begin
                cycle_num <= cycle_num + 7'd1;
            end
        end
    end

endmodule : line_timing

`default_nettype wire

/* verilog/raster.sv */
`default_nettype none

`include "vic_cfg.svh"

// Raster x and y position counters
module raster
    import vic_pkg::*;
(
    input  wire         clk_phi,
    input  wire         clk_dot4x,
    input  wire         rst,
    input  wire         phi_phase_start_0,
    input  wire         dot_rising_0,
    input  wire         dot_rising_2,
    input  wire chip_t  chip,
    input  wire  [6:0]  cycle_num,
    input  wire  [9:0]  raster_x_max,
    input  wire  [8:0]  raster_y_max,
    output logic [9:0]  xpos,
    output logic [9:0]  raster_x,
    output logic [9:0]  sprite_raster_x,
    output logic [8:0]  raster_line,
    output logic [8:0]  raster_line_d,
    output logic [10:0] hires_raster_x
);

    logic       start_of_line;
    logic       start_of_frame;
    chip_t      chip_q;

    // Pixel number within the bus cycle
    // Not valid on the first dot tick of the low phi phase
    logic [2:0] cycle_bit;

    assign cycle_bit = raster_x[2:0];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            chip_q         <= chip;
            raster_x       <= 10'd0;
            hires_raster_x <= 11'd0;
            raster_line    <= 9'd0;
            raster_line_d  <= 9'd0;
            start_of_line  <= 1'b0;
            start_of_frame <= 1'b0;
            case (chip)
                CHIP6567R56A: begin
                    xpos            <= `XPOS_START_6567;
                    sprite_raster_x <= `SPRITE_X_START_R56A;
                end
                CHIP6567R8: begin
                    xpos            <= `XPOS_START_6567;
                    sprite_raster_x <= `SPRITE_X_START_R8;
                end
                default: begin
                    xpos            <= `XPOS_START_6569;
                    sprite_raster_x <= `SPRITE_X_START_6569;
                end
            endcase
        end else begin
            // Delayed line number moves at the next low phi phase
            if (phi_phase_start_0 && start_of_line) begin
                raster_line_d <= raster_line;
                start_of_line <= 1'b0;
            end

            if (!clk_phi && start_of_frame && cycle_num == 7'd1) begin
                raster_line_d  <= 9'd0;
                start_of_frame <= 1'b0;
            end

            if (dot_rising_0) begin
                if (raster_x < raster_x_max) begin
                    raster_x       <= raster_x + 10'd1;
                    hires_raster_x <= hires_raster_x + 11'd1;

                    // Normal increment with a few per chip jumps
                    case (chip_q)
                        CHIP6567R8: begin
                            if (cycle_num == 7'd0 && cycle_bit == 3'd0)
                                xpos <= `XPOS_FIRST_6567;
                            else if (cycle_num == 7'd60 && cycle_bit == 3'd7)
                                xpos <= `XPOS_HOLD_R8;
                            else if (cycle_num == 7'd61 &&
                                     (cycle_bit == 3'd3 || cycle_bit == 3'd7))
                                xpos <= `XPOS_HOLD_R8;
                            else if (cycle_num == 7'd12 && cycle_bit == 3'd3)
                                xpos <= 10'd0;
                            else
                                xpos <= xpos + 10'd1;
                        end
                        CHIP6567R56A: begin
                            if (cycle_num == 7'd0 && cycle_bit == 3'd0)
                                xpos <= `XPOS_FIRST_6567;
                            else if (cycle_num == 7'd12 && cycle_bit == 3'd3)
                                xpos <= 10'd0;
                            else
                                xpos <= xpos + 10'd1;
                        end
                        default: begin
                            if (cycle_num == 7'd0 && cycle_bit == 3'd0)
                                xpos <= `XPOS_FIRST_6569;
                            else if (cycle_num == 7'd12 && cycle_bit == 3'd3)
                                xpos <= 10'd0;
                            else
                                xpos <= xpos + 10'd1;
                        end
                    endcase
                end else begin
                    // End of line
                    raster_x       <= 10'd0;
                    hires_raster_x <= 11'd0;
                    if (chip_q == CHIP6567R56A || chip_q == CHIP6567R8)
                        xpos <= `XPOS_START_6567;
                    else
                        xpos <= `XPOS_START_6569;

                    if (raster_line < raster_y_max) begin
                        raster_line   <= raster_line + 9'd1;
                        start_of_line <= 1'b1;
                    end else begin
                        raster_line    <= 9'd0;
                        start_of_frame <= 1'b1;
                    end
                end

                if (sprite_raster_x < raster_x_max)
                    sprite_raster_x <= sprite_raster_x + 10'd1;
                else
                    sprite_raster_x <= 10'd0;
            end

            // Second half of each dot for the hires counter
            if (dot_rising_2) begin
                hires_raster_x <= hires_raster_x + 11'd1;
            end
        end
    end

endmodule : raster

`default_nettype wire

/* verilog/badline_fsm.sv */
`default_nettype none

`include "vic_cfg.svh"

// Bad line detection, ba sequencing and raster interrupt
module badline_fsm
    import vic_pkg::*;
(
    input  wire        clk_dot4x,
    input  wire        rst,
    input  wire        phi_phase_start_0,
    input  wire  [6:0] cycle_num,
    input  wire  [8:0] raster_line,
    input  wire        den,
    input  wire  [2:0] yscroll,
    input  wire  [8:0] irq_line,
    output logic       ba,
    output logic       irq
);

    bus_state_t state;
    bus_state_t state_next;
    logic [6:0] next_cycle;
    logic       bad_line;
    logic [8:0] raster_line_q;
    logic       line_changed;

    // cycle_num still holds the old cycle in the phase start clock
    assign next_cycle = cycle_num + 7'd1;

    assign bad_line = den &&
                      (raster_line >= `BADLINE_FIRST) &&
                      (raster_line <= `BADLINE_LAST) &&
                      (raster_line[2:0] == yscroll);

    assign line_changed = (raster_line != raster_line_q);

    always_comb begin
        state_next = state;
        if (phi_phase_start_0) begin
            case (state)
                BUS_IDLE: begin
                    if (bad_line && next_cycle == `BA_FALL_CYCLE)
                        state_next = BUS_BA_WARN;
                end
                BUS_BA_WARN: begin
                    // Three cycles of warning before the fetches
                    if (next_cycle == `BA_DMA_CYCLE)
                        state_next = BUS_BA_DMA;
                end
                BUS_BA_DMA: begin
                    if (next_cycle == `BA_RISE_CYCLE)
                        state_next = BUS_RELEASE;
                end
                default: begin
                    state_next = BUS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            state         <= BUS_IDLE;
            ba            <= 1'b1;
            irq           <= 1'b0;
            // Out of range so that line 0 counts as a new line
            raster_line_q <= 9'h1ff;
        end else begin
            state         <= state_next;
            ba            <= !(state_next == BUS_BA_WARN || state_next == BUS_BA_DMA);
            raster_line_q <= raster_line;
            irq           <= line_changed && (raster_line == irq_line);
        end
    end

endmodule : badline_fsm

`default_nettype wire

/* verilog/vic_timing_top.sv */
`default_nettype none

// Video timing core
module vic_timing_top
    import vic_pkg::*;
(
    input  wire         clk_dot4x,
    input  wire         rst,
    input  wire chip_t  chip,
    input  wire         den,
    input  wire  [2:0]  yscroll,
    input  wire  [8:0]  irq_line,
    output logic [6:0]  cycle_num,
    output logic [9:0]  xpos,
    output logic [9:0]  raster_x,
    output logic [9:0]  sprite_raster_x,
    output logic [8:0]  raster_line,
    output logic [8:0]  raster_line_d,
    output logic [10:0] hires_raster_x,
    output logic        ba,
    output logic        irq
);

    logic       dot_rising_0;
    logic       dot_rising_2;
    logic       clk_phi;
    logic       phi_phase_start_0;
    logic [9:0] raster_x_max;
    logic [8:0] raster_y_max;

    dot_clock_gen u_dot_clock (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .dot_rising_0      (dot_rising_0),
        .dot_rising_2      (dot_rising_2),
        .clk_phi           (clk_phi),
        .phi_phase_start_0 (phi_phase_start_0)
    );

    line_timing u_line_timing (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .chip              (chip),
        .phi_phase_start_0 (phi_phase_start_0),
        .cycle_num         (cycle_num),
        .raster_x_max      (raster_x_max),
        .raster_y_max      (raster_y_max)
    );

    raster u_raster (
        .clk_phi           (clk_phi),
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .phi_phase_start_0 (phi_phase_start_0),
        .dot_rising_0      (dot_rising_0),
        .dot_rising_2      (dot_rising_2),
        .chip              (chip),
        .cycle_num         (cycle_num),
        .raster_x_max      (raster_x_max),
        .raster_y_max      (raster_y_max),
        .xpos              (xpos),
        .raster_x          (raster_x),
        .sprite_raster_x   (sprite_raster_x),
        .raster_line       (raster_line),
        .raster_line_d     (raster_line_d),
        .hires_raster_x    (hires_raster_x)
    );

    badline_fsm u_badline (
        .clk_dot4x         (clk_dot4x),
        .rst               (rst),
        .phi_phase_start_0 (phi_phase_start_0),
        .cycle_num         (cycle_num),
        .raster_line       (raster_line),
        .den               (den),
        .yscroll           (yscroll),
        .irq_line          (irq_line),
        .ba                (ba),
        .irq               (irq)
    );

endmodule : vic_timing_top

`default_nettype wire

/* tb/vic_timing_assertions.sv */
`default_nettype none

// Bus and raster invariants on the timing core
module vic_timing_assertions (
    input wire       clk_dot4x,
    input wire       rst,
    input wire [6:0] cycle_num,
    input wire [9:0] raster_x,
    input wire [9:0] raster_x_max,
    input wire       ba,
    input wire       irq
);

    // Read by the testbench after each clock
    int unsigned assert_errors = 0;

    // Bus is released by reset
    ba_high_after_reset: assert property (@(posedge clk_dot4x) rst |=> ba)
        else begin
            $error("ba is low in the clock after reset");
            assert_errors = assert_errors + 1;
        end

    irq_single_clock: assert property (@(posedge clk_dot4x) disable iff (rst)
        irq |=> !irq)
        else begin
            $error("irq stayed high for more than one clock");
            assert_errors = assert_errors + 1;
        end

    raster_x_in_line: assert property (@(posedge clk_dot4x) disable iff (rst)
        raster_x <= raster_x_max)
        else begin
            $error("raster_x is past the end of the line");
            assert_errors = assert_errors + 1;
        end

    // A new bus cycle begins on the first dot of a character
    cycle_on_dot_zero: assert property (@(posedge clk_dot4x) disable iff (rst)
        (cycle_num != $past(cycle_num)) |-> ($past(raster_x[2:0]) == 3'd0))
        else begin
            $error("cycle_num changed away from dot 0");
            assert_errors = assert_errors + 1;
        end

endmodule : vic_timing_assertions

bind vic_timing_top vic_timing_assertions u_assertions (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .cycle_num    (cycle_num),
    .raster_x     (raster_x),
    .raster_x_max (raster_x_max),
    .ba           (ba),
    .irq          (irq)
);

`default_nettype wire

/* tb/vic_timing_tb.sv */
`default_nettype none

`include "vic_cfg.svh"

// Testbench for the video timing core
module vic_timing_tb
    import vic_pkg::*;
();

    localparam int         LINE_WAIT_LIMIT = 700000;
    localparam logic [8:0] BAD_FIRST       = 9'h030;
    localparam logic [8:0] BAD_LAST        = 9'h0f7;

    logic        clk_dot4x;
    logic        rst;
    chip_t       chip;
    logic        den;
    logic [2:0]  yscroll;
    logic [8:0]  irq_line;
    logic [6:0]  cycle_num;
    logic [9:0]  xpos;
    logic [9:0]  raster_x;
    logic [9:0]  sprite_raster_x;
    logic [8:0]  raster_line;
    logic [8:0]  raster_line_d;
    logic [10:0] hires_raster_x;
    logic        ba;
    logic        irq;

    logic [31:0] seed;
    string       test_name;
    int          irq_count;

    // Reference model, one update per clock
    chip_t       m_chip;
    logic [9:0]  m_xmax;
    logic [8:0]  m_ymax;
    logic [6:0]  m_last;
    logic [4:0]  m_phase;
    logic        m_started;
    logic [6:0]  m_cycle;
    logic [9:0]  m_x;
    logic [9:0]  m_xpos;
    logic [9:0]  m_sx;
    logic [10:0] m_hx;
    logic [8:0]  m_line;
    logic [8:0]  m_line_d;
    logic        m_line_pending;
    logic        m_frame_pending;
    logic        m_entered;
    bus_state_t  m_bus;
    logic        m_ba;
    logic        m_irq;

    vic_timing_top i_dut (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .chip            (chip),
        .den             (den),
        .yscroll         (yscroll),
        .irq_line        (irq_line),
        .cycle_num       (cycle_num),
        .xpos            (xpos),
        .raster_x        (raster_x),
        .sprite_raster_x (sprite_raster_x),
        .raster_line     (raster_line),
        .raster_line_d   (raster_line_d),
        .hires_raster_x  (hires_raster_x),
        .ba              (ba),
        .irq             (irq)
    );

    always #20 clk_dot4x = ~clk_dot4x;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [9:0] line_last_x(input chip_t c);
        case (c)
            CHIP6567R56A: return 10'd511;
            CHIP6567R8:   return 10'd519;
            default:      return 10'd503;
        endcase
    endfunction

    function automatic logic [8:0] frame_last_line(input chip_t c);
        case (c)
            CHIP6567R56A: return 9'd261;
            CHIP6567R8:   return 9'd262;
            default:      return 9'd311;
        endcase
    endfunction

    function automatic logic [9:0] xpos_at_line_start(input chip_t c);
        return (c == CHIP6567R56A || c == CHIP6567R8) ? 10'h19c : 10'h194;
    endfunction

    // xpos after one dot, from the cycle and dot seen at that dot
    function automatic logic [9:0] xpos_after_dot(input chip_t c, input logic [6:0] cyc,
                                                  input logic [2:0] dot, input logic [9:0] xp);
        logic [9:0] result;
        result = xp + 10'd1;
        if (cyc == 7'd12 && dot == 3'd3)
            result = 10'd0;
        else if (cyc == 7'd0 && dot == 3'd0)
            result = (c == CHIP6567R56A || c == CHIP6567R8) ?
                     `XPOS_FIRST_6567 : `XPOS_FIRST_6569;
        else if (c == CHIP6567R8 && ((cyc == 7'd60 && dot == 3'd7) ||
                                     (cyc == 7'd61 && dot[1:0] == 2'd3)))
            result = `XPOS_HOLD_R8;
        return result;
    endfunction

    function void advance_model(input logic r, input chip_t c, input logic d,
                                input logic [2:0] ys, input logic [8:0] il);
        logic       dot0;
        logic       dot2;
        logic       pstart;
        logic       phi_high;
        logic [6:0] cyc_old;
        logic [9:0] x_old;
        logic [8:0] line_old;
        logic       bad;
        if (r) begin
            m_chip          = c;
            m_xmax          = line_last_x(c);
            m_ymax          = frame_last_line(c);
            m_last          = 7'((m_xmax + 10'd1) / 8 - 1);
            m_phase         = 5'd0;
            m_started       = 1'b0;
            m_cycle         = 7'd0;
            m_x             = 10'd0;
            m_hx            = 11'd0;
            m_line          = 9'd0;
            m_line_d        = 9'd0;
            m_line_pending  = 1'b0;
            m_frame_pending = 1'b0;
            m_entered       = 1'b1;
            m_xpos          = xpos_at_line_start(c);
            m_sx            = (c == CHIP6567R8) ? 10'd80 : 10'd72;
            m_bus           = BUS_IDLE;
            m_ba            = 1'b1;
            m_irq           = 1'b0;
        end else begin
            dot0     = (m_phase[1:0] == 2'd0);
            dot2     = (m_phase[1:0] == 2'd2);
            pstart   = (m_phase == 5'd0);
            phi_high = m_phase[4];
            cyc_old  = m_cycle;
            x_old    = m_x;
            line_old = m_line;
            m_phase  = m_phase + 5'd1;

            // Interrupt in the clock after a new line value
            m_irq     = m_entered && (line_old == il);
            m_entered = 1'b0;

            if (pstart) begin
                if (m_started)
                    m_cycle = (cyc_old == m_last) ? 7'd0 : cyc_old + 7'd1;
                m_started = 1'b1;
            end

            if (pstart && m_line_pending) begin
                m_line_d       = line_old;
                m_line_pending = 1'b0;
            end
            if (!phi_high && m_frame_pending && cyc_old == 7'd1) begin
                m_line_d        = 9'd0;
                m_frame_pending = 1'b0;
            end

            if (dot0) begin
                m_sx = (m_sx == m_xmax) ? 10'd0 : m_sx + 10'd1;
                if (x_old == m_xmax) begin
                    m_x       = 10'd0;
                    m_hx      = 11'd0;
                    m_xpos    = xpos_at_line_start(m_chip);
                    m_entered = 1'b1;
                    if (line_old == m_ymax) begin
                        m_line          = 9'd0;
                        m_frame_pending = 1'b1;
                    end else begin
                        m_line         = line_old + 9'd1;
                        m_line_pending = 1'b1;
                    end
                end else begin
                    m_x    = x_old + 10'd1;
                    m_hx   = m_hx + 11'd1;
                    m_xpos = xpos_after_dot(m_chip, cyc_old, x_old[2:0], m_xpos);
                end
            end
            if (dot2)
                m_hx = m_hx + 11'd1;

            // Bus state moves at the start of each bus cycle
            bad = d && line_old >= BAD_FIRST && line_old <= BAD_LAST && line_old[2:0] == ys;
            if (pstart) begin
                case (m_bus)
                    BUS_IDLE:    if (bad && m_cycle == 7'd12) m_bus = BUS_BA_WARN;
                    BUS_BA_WARN: if (m_cycle == 7'd15) m_bus = BUS_BA_DMA;
                    BUS_BA_DMA:  if (m_cycle == 7'd55) m_bus = BUS_RELEASE;
                    default:     m_bus = BUS_IDLE;
                endcase
            end
            m_ba = !(m_bus == BUS_BA_WARN || m_bus == BUS_BA_DMA);
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic wait_for_line(input logic [8:0] line);
        int clocks;
        clocks = 0;
        while (raster_line !== line) begin
            @(negedge clk_dot4x);
            clocks++;
            if (clocks > LINE_WAIT_LIMIT)
                report_failure($sformatf("raster_line never reached %0d", line));
        end
    endtask

    // One frame plus one line for a chip, starting from reset
    task automatic run_chip(input int run);
        chip_t      c;
        logic [8:0] last_line;
        logic       den_pick;
        int         irq_pick;
        int         expected_irqs;
        c         = chip_t'(run);
        last_line = frame_last_line(c);
        test_name = c.name();
        seed      = lcg_next(seed);
        den_pick  = seed[27];
        seed      = lcg_next(seed);
        // Even runs put irq_line inside the frame and odd runs outside it
        if (run % 2 == 0)
            irq_pick = int'(seed[23:8]) % (int'(last_line) + 1);
        else
            irq_pick = int'(last_line) + 1 + int'(seed[23:8]) % (510 - int'(last_line));

        @(posedge clk_dot4x);
        #2;
        rst       = 1'b1;
        chip      = c;
        den       = (run == 3) ? 1'b0 : ((run == 0) ? 1'b1 : den_pick);
        yscroll   = seed[30:28];
        irq_line  = irq_pick[8:0];
        irq_count = 0;
        repeat (2) @(posedge clk_dot4x);
        #2;
        rst  = 1'b0;
        // Chip select is only taken in reset
        chip = chip_t'((run + 1) % 4);

        wait_for_line(last_line);
        wait_for_line(9'd0);
        wait_for_line(9'd1);

        // Line 0 is entered twice, every other line once
        if (irq_line > last_line)
            expected_irqs = 0;
        else if (irq_line == 9'd0)
            expected_irqs = 2;
        else
            expected_irqs = 1;
        check_value("irq pulse count", expected_irqs, irq_count);
    endtask

    // Model steps on the edge and DUT outputs are compared mid cycle
    initial begin
        forever begin
            @(posedge clk_dot4x);
            advance_model(rst, chip, den, yscroll, irq_line);
            @(negedge clk_dot4x);
            check_value("cycle_num", m_cycle, cycle_num);
            check_value("raster_x", m_x, raster_x);
            check_value("xpos", m_xpos, xpos);
            check_value("sprite_raster_x", m_sx, sprite_raster_x);
            check_value("hires_raster_x", m_hx, hires_raster_x);
            check_value("raster_line", m_line, raster_line);
            check_value("raster_line_d", m_line_d, raster_line_d);
            check_value("ba", m_ba, ba);
            check_value("irq", m_irq, irq);
            if (irq === 1'b1)
                irq_count++;
            if (i_dut.u_assertions.assert_errors != 0)
                report_failure("a bound assertion on the DUT failed");
        end
    end

    initial begin
        clk_dot4x   = 1'b0;
        rst         = 1'b1;
        chip        = CHIP6567R56A;
        den         = 1'b0;
        yscroll     = 3'd0;
        irq_line    = 9'd0;
        seed        = 32'hb0b24c46;
        irq_count   = 0;
        test_name   = "startup";

        for (int run = 0; run < 4; run++) begin
            run_chip(run);
        end

        if (i_dut.u_assertions.assert_errors == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "a bound assertion on the DUT failed");
        end
    end

endmodule : vic_timing_tb

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/vic_pkg.sv
verilog/dot_clock_gen.sv
verilog/line_timing.sv
verilog/raster.sv
verilog/badline_fsm.sv
verilog/vic_timing_top.sv
tb/vic_timing_assertions.sv
tb/vic_timing_tb.sv
